// File: hw/rippleAdder.sv
`default_nettype none

module rippleAdder (
	input wire [smArithPkg::magWidth-1:0] in1,
	input wire [smArithPkg::magWidth-1:0] in2,
	input wire sub,
	output wire [smArithPkg::magWidth-1:0] sum,
	output wire cOut
);

	logic [smArithPkg::magWidth-1:0] addend;
	logic [smArithPkg::magWidth:0] carry;

	// ones complement of in2 plus a carry-in gives in1 - in2.
	assign addend = in2 ^ {smArithPkg::magWidth{sub}};
	assign carry[0] = sub;

	genvar i;
	generate
		for (i = 0; i < smArithPkg::magWidth; i = i + 1) begin : gStage
			assign sum[i] = in1[i] ^ addend[i] ^ carry[i];
			assign carry[i + 1] = (in1[i] & addend[i])
				| (addend[i] & carry[i])
				| (carry[i] & in1[i]);
		end
	endgenerate

	assign cOut = carry[smArithPkg::magWidth]; // no borrow when subtracting.

endmodule

`default_nettype wire

// File: hw/smAddSub.sv
`default_nettype none

module smAddSub (
	input wire clk,
	input wire nRST,
	input wire start,
	input wire sub,
	input wire [smArithPkg::dataWidth-1:0] operand1,
	input wire [smArithPkg::dataWidth-1:0] operand2,
	output logic [smArithPkg::dataWidth-1:0] sum,
	output logic overflow,
	output logic finish
);

	smArithPkg::addState_t state;
	smArithPkg::addState_t nextState;

	logic [smArithPkg::magWidth-1:0] n1;
	logic [smArithPkg::magWidth-1:0] n2;
	logic diffSign;
	logic sameSign;
	logic sign2;

	logic [smArithPkg::magWidth-1:0] adderOut;
	logic adderCOut;
	logic [smArithPkg::magWidth-1:0] comp;

	assign sign2 = operand2[smArithPkg::signBit] ^ sub; // subtract flips the sign.

	rippleAdder mainAdder (
		.in1(n1),
		.in2(n2),
		.sub(diffSign),
		.sum(adderOut),
		.cOut(adderCOut)
	);

	// negates the main result when the subtraction borrows.
	rippleAdder complementer (
		.in1('0),
		.in2(adderOut),
		.sub(1'b1),
		.sum(comp),
		.cOut()
	);

	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			state <= smArithPkg::sIdle;
			finish <= 1'b0;
		end else begin
			state <= nextState;
			finish <= (state == smArithPkg::sFin) && start; // held until start falls.
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			smArithPkg::sIdle: begin
				if (start) begin
					nextState = smArithPkg::sSet;
				end
			end
			smArithPkg::sSet: begin
				nextState = smArithPkg::sAdd;
			end
			smArithPkg::sAdd: begin
				nextState = smArithPkg::sFin;
			end
			smArithPkg::sFin: begin
				if (!start) begin
					nextState = smArithPkg::sIdle;
				end
			end
			default: begin
				nextState = smArithPkg::sIdle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		case (state)
			smArithPkg::sSet: begin
				sameSign <= operand1[smArithPkg::signBit];
				if (operand1[smArithPkg::signBit] ^ sign2) begin
					diffSign <= 1'b1;
					// positive magnitude minus negative magnitude.
					if (operand1[smArithPkg::signBit]) begin
						n1 <= operand2[smArithPkg::magWidth-1:0];
						n2 <= operand1[smArithPkg::magWidth-1:0];
					end else begin
						n1 <= operand1[smArithPkg::magWidth-1:0];
						n2 <= operand2[smArithPkg::magWidth-1:0];
					end
				end else begin
					diffSign <= 1'b0;
					n1 <= operand1[smArithPkg::magWidth-1:0];
					n2 <= operand2[smArithPkg::magWidth-1:0];
				end
			end
			smArithPkg::sAdd: begin
				if (diffSign && !adderCOut) begin
					sum <= {1'b1, comp}; // negative magnitude was the larger one.
					overflow <= 1'b0;
				end else begin
					sum[smArithPkg::signBit] <= diffSign ? 1'b0 : sameSign;
					sum[smArithPkg::magWidth-1:0] <= adderOut;
					overflow <= !diffSign && adderCOut;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/smArith.sv
`default_nettype none

module smArith (
	input wire clk,
	input wire nRST,
	input wire start,
	input wire smArithPkg::opcode_t op,
	input wire [smArithPkg::dataWidth-1:0] a,
	input wire [smArithPkg::dataWidth-1:0] b,
	output wire [smArithPkg::dataWidth-1:0] result,
	output wire overflow,
	output wire finish
);

	wire [smArithPkg::dataWidth-1:0] operand1;
	wire [smArithPkg::dataWidth-1:0] operand2;
	wire [smArithPkg::dataWidth-1:0] addSum;
	wire [smArithPkg::dataWidth-1:0] mulProduct;
	wire sub;
	wire addStart;
	wire mulStart;
	wire addOverflow;
	wire mulOverflow;
	wire addFinish;
	wire mulFinish;

	smArithCtrl ctrl (
		.clk(clk),
		.nRST(nRST),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.operand1(operand1),
		.operand2(operand2),
		.sub(sub),
		.addStart(addStart),
		.mulStart(mulStart),
		.addSum(addSum),
		.mulProduct(mulProduct),
		.addOverflow(addOverflow),
		.mulOverflow(mulOverflow),
		.addFinish(addFinish),
		.mulFinish(mulFinish),
		.result(result),
		.overflow(overflow),
		.finish(finish)
	);

	smAddSub addSubUnit (
		.clk(clk),
		.nRST(nRST),
		.start(addStart),
		.sub(sub),
		.operand1(operand1),
		.operand2(operand2),
		.sum(addSum),
		.overflow(addOverflow),
		.finish(addFinish)
	);

	smMultiply mulUnit (
		.clk(clk),
		.nRST(nRST),
		.start(mulStart),
		.operand1(operand1),
		.operand2(operand2),
		.product(mulProduct),
		.overflow(mulOverflow),
		.finish(mulFinish)
	);

endmodule

`default_nettype wire

// File: hw/smArithCtrl.sv
`default_nettype none

module smArithCtrl (
	input wire clk,
	input wire nRST,
	input wire start,
	input wire smArithPkg::opcode_t op,
	input wire [smArithPkg::dataWidth-1:0] a,
	input wire [smArithPkg::dataWidth-1:0] b,
	output logic [smArithPkg::dataWidth-1:0] operand1,
	output logic [smArithPkg::dataWidth-1:0] operand2,
	output logic sub,
	output logic addStart,
	output logic mulStart,
	input wire [smArithPkg::dataWidth-1:0] addSum,
	input wire [smArithPkg::dataWidth-1:0] mulProduct,
	input wire addOverflow,
	input wire mulOverflow,
	input wire addFinish,
	input wire mulFinish,
	output logic [smArithPkg::dataWidth-1:0] result,
	output logic overflow,
	output logic finish
);

	smArithPkg::ctrlState_t state;
	smArithPkg::opcode_t opReg;

	logic [smArithPkg::dataWidth-1:0] unitResult;
	logic unitOverflow;
	logic unitFinish;

	assign sub = opReg == smArithPkg::opSub;

	always_comb begin
		if (opReg == smArithPkg::opMul) begin
			unitResult = mulProduct;
			unitOverflow = mulOverflow;
			unitFinish = mulFinish;
		end else begin
			unitResult = addSum;
			unitOverflow = addOverflow;
			unitFinish = addFinish;
		end
	end

	always_ff @(posedge clk) begin
		if (state == smArithPkg::cIdle && start) begin
			operand1 <= a; // held for the unit while it runs.
			operand2 <= b;
		end
	end

	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			state <= smArithPkg::cIdle;
			opReg <= smArithPkg::opAdd;
			addStart <= 1'b0;
			mulStart <= 1'b0;
			result <= '0;
			overflow <= 1'b0;
			finish <= 1'b0;
		end else begin
			case (state)
				smArithPkg::cIdle: begin
					if (start) begin
						opReg <= op;
						addStart <= op != smArithPkg::opMul;
						mulStart <= op == smArithPkg::opMul;
						state <= smArithPkg::cRun;
					end
				end
				smArithPkg::cRun: begin
					if (unitFinish) begin
						result <= unitResult;
						overflow <= unitOverflow;
						finish <= 1'b1;
						state <= smArithPkg::cDone;
					end
				end
				smArithPkg::cDone: begin
					if (!start) begin
						addStart <= 1'b0; // unit goes idle on the next edge.
						mulStart <= 1'b0;
						finish <= 1'b0;
						state <= smArithPkg::cIdle;
					end
				end
				default: begin
					state <= smArithPkg::cIdle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/smArithPkg.sv
`default_nettype none

package smArithPkg;

	localparam int dataWidth = 16;
	localparam int magWidth = 15;
	localparam int signBit = 15;
	localparam int mulSteps = 15; // one step per multiplier bit.

	typedef enum logic [1:0] {
		opAdd,
		opSub,
		opMul
	} opcode_t;

	typedef enum logic [1:0] {
		sIdle,
		sSet,
		sAdd,
		sFin
	} addState_t;

	typedef enum logic [1:0] {
		mIdle,
		mLoad,
		mStep,
		mFin
	} mulState_t;

	typedef enum logic [1:0] {
		cIdle,
		cRun,
		cDone
	} ctrlState_t;

endpackage

`default_nettype wire

// File: hw/smMultiply.sv
`default_nettype none

module smMultiply (
	input wire clk,
	input wire nRST,
	input wire start,
	input wire [smArithPkg::dataWidth-1:0] operand1,
	input wire [smArithPkg::dataWidth-1:0] operand2,
	output logic [smArithPkg::dataWidth-1:0] product,
	output logic overflow,
	output logic finish
);

	smArithPkg::mulState_t state;
	smArithPkg::mulState_t nextState;

	logic [3:0] stepCount;
	logic lastStep;

	logic [smArithPkg::magWidth-1:0] mcand;
	logic [2*smArithPkg::magWidth-1:0] acc; // partial product over multiplier.
	logic sign;

	logic [smArithPkg::magWidth-1:0] partialSum;
	logic partialCOut;

	assign lastStep = stepCount == 4'(smArithPkg::mulSteps - 1);

	rippleAdder stepAdder (
		.in1(acc[2*smArithPkg::magWidth-1:smArithPkg::magWidth]),
		.in2(mcand),
		.sub(1'b0),
		.sum(partialSum),
		.cOut(partialCOut)
	);

	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			state <= smArithPkg::mIdle;
			stepCount <= '0;
			finish <= 1'b0;
		end else begin
			state <= nextState;
			finish <= (state == smArithPkg::mFin) && start;
			if (state == smArithPkg::mStep) begin
				stepCount <= stepCount + 4'd1;
			end else begin
				stepCount <= '0;
			end
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			smArithPkg::mIdle: begin
				if (start) begin
					nextState = smArithPkg::mLoad;
				end
			end
			smArithPkg::mLoad: begin
				nextState = smArithPkg::mStep;
			end
			smArithPkg::mStep: begin
				if (lastStep) begin
					nextState = smArithPkg::mFin;
				end
			end
			smArithPkg::mFin: begin
				if (!start) begin
					nextState = smArithPkg::mIdle;
				end
			end
			default: begin
				nextState = smArithPkg::mIdle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		case (state)
			smArithPkg::mLoad: begin
				mcand <= operand1[smArithPkg::magWidth-1:0];
				acc <= {{smArithPkg::magWidth{1'b0}}, operand2[smArithPkg::magWidth-1:0]};
				sign <= operand1[smArithPkg::signBit] ^ operand2[smArithPkg::signBit];
			end
			smArithPkg::mStep: begin
				if (acc[0]) begin
					acc <= {partialCOut, partialSum, acc[smArithPkg::magWidth-1:1]};
				end else begin
					acc <= {1'b0, acc[2*smArithPkg::magWidth-1:1]};
				end
			end
			smArithPkg::mFin: begin
				// only the low 15 bits are kept, zero is always positive.
				product <= {sign & (|acc[smArithPkg::magWidth-1:0]),
					acc[smArithPkg::magWidth-1:0]};
				overflow <= |acc[2*smArithPkg::magWidth-1:smArithPkg::magWidth];
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Compile and run the smArith testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f smArith.f --top-module smArithTb -o smArithSim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

output=$(./obj_dir/smArithSim)
runStatus=$?
echo "$output"
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1

// File: smArith.f
hw/smArithPkg.sv
hw/rippleAdder.sv
hw/smAddSub.sv
hw/smMultiply.sv
hw/smArithCtrl.sv
hw/smArith.sv
testbench/smArithChecker.sv
testbench/smArithTb.sv

// File: testbench/smArithChecker.sv
`default_nettype none

module smArithChecker (
	input wire clk,
	input wire nRST,
	input wire start,
	input wire smArithPkg::opcode_t op,
	input wire [smArithPkg::dataWidth-1:0] a,
	input wire [smArithPkg::dataWidth-1:0] b,
	input wire [127:0] testName,
	input wire [smArithPkg::dataWidth-1:0] result,
	input wire overflow,
	input wire finish,
	output int errorCount,
	output int checkCount
);

	timeunit 1ns;
	timeprecision 1ps;

	logic startPrev;
	logic finishPrev;
	logic busy;
	logic seenOp;
	logic [smArithPkg::dataWidth:0] expected; // overflow above the result.
	logic [127:0] curName;
	logic [smArithPkg::dataWidth-1:0] heldResult;
	logic heldOverflow;
	int lowCount;

	function automatic logic [smArithPkg::dataWidth:0] expectedOf(
		input smArithPkg::opcode_t opIn,
		input logic [smArithPkg::dataWidth-1:0] x,
		input logic [smArithPkg::dataWidth-1:0] y
	);
		logic signX;
		logic signY;
		logic signOut;
		logic [smArithPkg::magWidth-1:0] magX;
		logic [smArithPkg::magWidth-1:0] magY;
		logic [smArithPkg::magWidth-1:0] magOut;
		logic [smArithPkg::magWidth:0] magSum;
		logic [2*smArithPkg::magWidth-1:0] prod;
		logic ovf;
		signX = x[smArithPkg::signBit];
		signY = y[smArithPkg::signBit] ^ (opIn == smArithPkg::opSub); // subtract flips b.
		magX = x[smArithPkg::magWidth-1:0];
		magY = y[smArithPkg::magWidth-1:0];
		ovf = 1'b0;
		if (opIn == smArithPkg::opMul) begin
			prod = {{smArithPkg::magWidth{1'b0}}, magX} * {{smArithPkg::magWidth{1'b0}}, magY};
			magOut = prod[smArithPkg::magWidth-1:0];
			ovf = |prod[2*smArithPkg::magWidth-1:smArithPkg::magWidth];
			signOut = (x[smArithPkg::signBit] ^ y[smArithPkg::signBit]) && (magOut != '0);
		end else if (signX == signY) begin
			magSum = {1'b0, magX} + {1'b0, magY};
			magOut = magSum[smArithPkg::magWidth-1:0];
			ovf = magSum[smArithPkg::magWidth];
			signOut = signX; // kept even for a zero sum.
		end else if (magX > magY) begin
			signOut = signX;
			magOut = magX - magY;
		end else if (magY > magX) begin
			signOut = signY;
			magOut = magY - magX;
		end else begin
			signOut = 1'b0;
			magOut = '0;
		end
		return {ovf, signOut, magOut};
	endfunction

	always @(posedge clk) begin
		if (!nRST) begin
			startPrev <= 1'b0;
			finishPrev <= 1'b0;
			busy <= 1'b0;
			seenOp <= 1'b0;
			lowCount <= 0;
		end else begin
			startPrev <= start;
			finishPrev <= finish;
			if (!seenOp && (finish !== 1'b0 || result !== '0)) begin
				$display("ERROR: finish or result left its reset value before the first operation");
				errorCount = errorCount + 1;
			end
			if (start && !startPrev) begin
				expected <= expectedOf(op, a, b);
				curName <= testName;
				busy <= 1'b1;
				seenOp <= 1'b1;
			end
			if (finish && !busy) begin
				$display("ERROR: finish rose with no operation started");
				errorCount = errorCount + 1;
			end
			if (finish && !finishPrev && busy) begin
				checkCount = checkCount + 1;
				heldResult <= result;
				heldOverflow <= overflow;
				if (result !== expected[smArithPkg::dataWidth-1:0]) begin
					$display("MISMATCH %0s: result expected %h actual %h", curName,
						expected[smArithPkg::dataWidth-1:0], result);
					errorCount = errorCount + 1;
				end
				if (overflow !== expected[smArithPkg::dataWidth]) begin
					$display("MISMATCH %0s: overflow expected %b actual %b", curName,
						expected[smArithPkg::dataWidth], overflow);
					errorCount = errorCount + 1;
				end
			end
			if (finish && finishPrev && start
				&& (result !== heldResult || overflow !== heldOverflow)) begin
				$display("ERROR: %0s: result changed while start was held", curName);
				errorCount = errorCount + 1;
			end
			if (!finish && finishPrev && start) begin
				$display("ERROR: %0s: finish fell while start was still high", curName);
				errorCount = errorCount + 1;
			end
			if (!finish && finishPrev) begin
				busy <= 1'b0;
			end
			if (finish && !start) begin
				lowCount <= lowCount + 1;
				if (lowCount >= 1) begin
					$display("ERROR: %0s: finish stayed high after start fell", curName);
					errorCount = errorCount + 1;
				end
			end else begin
				lowCount <= 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/smArithTb.sv
`default_nettype none

module smArithTb;

	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic nRST;
	logic start;
	smArithPkg::opcode_t op;
	logic [smArithPkg::dataWidth-1:0] a;
	logic [smArithPkg::dataWidth-1:0] b;
	wire [smArithPkg::dataWidth-1:0] result;
	wire overflow;
	wire finish;

	logic [127:0] testName;
	logic [127:0] names[$];
	smArithPkg::opcode_t ops[$];
	logic [smArithPkg::dataWidth-1:0] aValues[$];
	logic [smArithPkg::dataWidth-1:0] bValues[$];
	int errorCount;
	int checkCount;
	int totalErrors;
	int cycles;
	int limit;
	int seed;
	int i;

	smArith i_dut (
		.clk(clk),
		.nRST(nRST),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.result(result),
		.overflow(overflow),
		.finish(finish)
	);

	smArithChecker resultChecker (
		.clk(clk),
		.nRST(nRST),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.testName(testName),
		.result(result),
		.overflow(overflow),
		.finish(finish),
		.errorCount(errorCount),
		.checkCount(checkCount)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("ERROR: timeout after %0d cycles, the DUT never finished", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic addEntry(input string name, input smArithPkg::opcode_t entryOp,
		input logic [15:0] entryA, input logic [15:0] entryB);
		logic [127:0] nameBits;
		int k;
		nameBits = '0;
		for (k = 0; k < name.len(); k++) begin
			nameBits = {nameBits[119:0], name[k]};
		end
		names.push_back(nameBits);
		ops.push_back(entryOp);
		aValues.push_back(entryA);
		bValues.push_back(entryB);
	endtask

	task automatic buildTable();
		logic [31:0] rnd;
		logic [31:0] rndOp;
		smArithPkg::opcode_t randOp;
		int n;
		addEntry("addPos", smArithPkg::opAdd, 16'h0003, 16'h0005);
		addEntry("addNeg", smArithPkg::opAdd, 16'h8003, 16'h8005);
		addEntry("addCarry", smArithPkg::opAdd, 16'h4000, 16'h4000);
		addEntry("addNegCarry", smArithPkg::opAdd, 16'hffff, 16'h8001);
		addEntry("addMixPos", smArithPkg::opAdd, 16'h0010, 16'h8004);
		addEntry("addMixNeg", smArithPkg::opAdd, 16'h0004, 16'h8010);
		addEntry("addNegLarger", smArithPkg::opAdd, 16'h8010, 16'h0004);
		addEntry("addNegSmaller", smArithPkg::opAdd, 16'h8004, 16'h0010);
		addEntry("addEqualMag", smArithPkg::opAdd, 16'h1234, 16'h9234);
		addEntry("addNegZero", smArithPkg::opAdd, 16'h8000, 16'h8000);
		addEntry("subPos", smArithPkg::opSub, 16'h0009, 16'h0004);
		addEntry("subToNeg", smArithPkg::opSub, 16'h0004, 16'h0009);
		addEntry("subNegValue", smArithPkg::opSub, 16'h0004, 16'h8009);
		addEntry("subEqual", smArithPkg::opSub, 16'h8007, 16'h8007);
		addEntry("mulSignMix", smArithPkg::opMul, 16'h8003, 16'h0005);
		addEntry("mulBothNeg", smArithPkg::opMul, 16'h8006, 16'h8007);
		addEntry("mulWrapZero", smArithPkg::opMul, 16'h8200, 16'h0100);
		addEntry("mulZero", smArithPkg::opMul, 16'h8000, 16'h1234);
		addEntry("mulMax", smArithPkg::opMul, 16'h7fff, 16'h7fff);
		seed = 32'h4bb6;
		for (n = 0; n < 8; n++) begin
			rndOp = $random(seed);
			rnd = $random(seed);
			if (rndOp[7:0] < 8'd86) begin
				randOp = smArithPkg::opAdd;
			end else if (rndOp[7:0] < 8'd171) begin
				randOp = smArithPkg::opSub;
			end else begin
				randOp = smArithPkg::opMul;
			end
			addEntry($sformatf("random%0d", n), randOp, rnd[31:16], rnd[15:0]);
		end
	endtask

	initial begin
		nRST = 1'b0;
		start = 1'b0;
		op = smArithPkg::opAdd;
		a = '0;
		b = '0;
		testName = '0;
		cycles = 0;
		limit = 0;
		buildTable();
		limit = names.size() * (smArithPkg::mulSteps + 10) + 50;
		repeat (4) @(posedge clk);
		nRST <= 1'b1;
		repeat (3) @(posedge clk); // idle outputs checked here.
		for (i = 0; i < names.size(); i++) begin
			testName <= names[i];
			op <= ops[i];
			a <= aValues[i];
			b <= bValues[i];
			start <= 1'b1;
			@(posedge clk);
			while (finish !== 1'b1) @(posedge clk);
			repeat (2) @(posedge clk); // result must hold while start stays high.
			start <= 1'b0;
			@(posedge clk);
			while (finish === 1'b1) @(posedge clk);
			repeat (2) @(posedge clk);
		end
		repeat (2) @(posedge clk);
		totalErrors = errorCount;
		if (checkCount != names.size()) begin
			$display("ERROR: only %0d of %0d operations were checked", checkCount, names.size());
			totalErrors = totalErrors + 1;
		end
		$display("errors: %0d, operations checked: %0d of %0d", totalErrors, checkCount,
			names.size());
		if (totalErrors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
